/* src.f */
+incdir+include
source/daq_pkg.sv
source/wb_if.sv
source/ram_wb.sv
source/adc_front.sv
source/console.sv
source/pkt_tx.sv
source/pkt_rx.sv
source/daq_top.sv
testbench/tb_daq.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal --top-module tb_daq -f src.f
output=$(./obj_dir/Vtb_daq)
echo "$output"
echo "$output" | grep -q "Result: PASSED"

/* testbench/tb_daq.sv */
`timescale 1ns/1ps
`include "daq_config.svh"

module tb_daq;
    typedef logic [7:0] byte_q_t [$];

    logic       clk;
    logic       rst;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic [7:0] adc_data;
    logic       adc_valid;
    logic [7:0] adc_temp;

    logic [31:0] lfsr;
    int          ready_mode;
    int          errors;
    int          tests_run;
    int          tests_ok;
    int          frames_seen;
    bit          aborted;
    bit          exp_valid;
    string       exp_name;
    byte_q_t     exp_q;
    byte_q_t     cur;
    byte_q_t     got;
    event        frame_done;

    daq_top u_daq_top (.*);

    always #4 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    // sync, type, length high, length low, payload, xor of type through payload
    function automatic byte_q_t expected_frame(input logic [7:0] btype, input byte_q_t payload);
        byte_q_t    f;
        logic [7:0] cs;
        int         n;
        n = payload.size();
        f = {};
        f.push_back(`DAQ_SYNC);
        f.push_back(btype);
        f.push_back(8'(n >> 8));
        f.push_back(8'(n));
        cs = btype ^ 8'(n >> 8) ^ 8'(n);
        foreach (payload[i]) begin
            f.push_back(payload[i]);
            cs = cs ^ payload[i];
        end
        f.push_back(cs);
        return f;
    endfunction

    // host stall pattern with about one cycle in four held off in random mode
    always @(negedge clk) begin
        case (ready_mode)
            0: tx_ready = 1'b0;
            1: tx_ready = 1'b1;
            default: tx_ready = (rand_bits(2) != 8'd0);
        endcase
    end

    // frame collector
    always @(posedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            cur.push_back(tx_data);
            if (cur[0] != `DAQ_SYNC) begin
                cur = {};
            end else if (cur.size() >= 4 && cur.size() == 5 + {cur[2], cur[3]}) begin
                got = cur;
                cur = {};
                frames_seen++;
                -> frame_done;
            end
        end
    end

    // comparison against the pending expected frame
    always @(frame_done) begin : compare_frames
        int n;
        assert (exp_valid) else begin
            errors++;
            $display("a frame of type %h arrived when no reply was expected", got[1]);
        end
        if (exp_valid) begin
            n = (got.size() < exp_q.size()) ? got.size() : exp_q.size();
            assert (got.size() == exp_q.size()) else begin
                errors++;
                $display("[FAIL] %s length: expected %0d, actual %0d",
                         exp_name, exp_q.size(), got.size());
            end
            for (int i = 0; i < n; i++) begin
                assert (got[i] == exp_q[i]) else begin
                    errors++;
                    $display("[FAIL] %s byte %0d: expected %h, actual %h",
                             exp_name, i, exp_q[i], got[i]);
                end
            end
            exp_valid = 1'b0;
        end
    end

    task automatic send_cmd(input logic [7:0] btype, input logic [7:0] csum);
        @(negedge clk);
        rx_data  = `DAQ_SYNC;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_data = btype;
        @(negedge clk);
        rx_data = csum;
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic wait_reply(input int limit);
        int n;
        n = 0;
        while (exp_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_valid) begin
            $display("no %s reply arrived within %0d cycles", exp_name, limit);
            errors++;
            aborted = 1'b1;
            exp_valid = 1'b0;
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests_run++;
        if (errors == err_before && !aborted) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
        end
    endtask

    task automatic run_query(input string name, input logic [7:0] cmd, input logic [7:0] rtype,
                             input logic [7:0] word0, input logic [7:0] word1);
        int      e0;
        byte_q_t payload;
        e0 = errors;
        payload.push_back(word0);
        payload.push_back(word1);
        exp_q     = expected_frame(rtype, payload);
        exp_name  = name;
        exp_valid = 1'b1;
        send_cmd(cmd, cmd);
        wait_reply(400);
        report(name, e0);
    endtask

    task automatic run_conv(input int k);
        int      e0;
        byte_q_t pl;
        e0 = errors;
        pl.push_back(8'(k % `DAQ_FRAMES));
        pl.push_back(8'(`DAQ_BLOCK));
        for (int i = 0; i < `DAQ_BLOCK; i++) begin
            pl.push_back(rand_bits(8));
        end
        exp_q     = expected_frame((k % 2) ? 8'd14 : 8'd13, pl);
        exp_name  = $sformatf("conv%0d", k);
        exp_valid = 1'b1;
        send_cmd(8'd7, 8'd7);
        // give the front end time to reach its sample wait
        repeat (20) @(negedge clk);
        for (int i = 0; i < `DAQ_BLOCK; i++) begin
            adc_data  = pl[i + 2];
            adc_valid = 1'b1;
            @(negedge clk);
            adc_valid = 1'b0;
            repeat (5) @(negedge clk);
        end
        wait_reply(1000);
        report(exp_name, e0);
    endtask

    initial begin
        int      e0;
        int      n;
        int      f0;
        int      drops;
        logic    prev_valid;
        byte_q_t pl;
        clk        = 1'b0;
        rst        = 1'b1;
        rx_data    = 8'h00;
        rx_valid   = 1'b0;
        tx_ready   = 1'b0;
        adc_data   = 8'h00;
        adc_valid  = 1'b0;
        adc_temp   = 8'h47;
        lfsr       = 32'h81c6a6a6;
        ready_mode = 0;
        errors     = 0;
        tests_run  = 0;
        tests_ok   = 0;
        frames_seen = 0;
        aborted    = 1'b0;
        exp_valid  = 1'b0;
        exp_name   = "";
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // link announcement against a stalled host
        e0 = errors;
        n = 0;
        drops = 0;
        prev_valid = 1'b0;
        while (n < 2 * `DAQ_TX_TIMEOUT) begin
            @(negedge clk);
            // a frame that stops being offered was abandoned by the stall timeout
            if (prev_valid && !tx_valid) drops++;
            prev_valid = tx_valid;
            n++;
        end
        assert (drops > 0) else begin
            errors++;
            $display("the frame offered to the stalled host was never abandoned");
        end
        pl.push_back(`DAQ_LINK_WORD);
        pl.push_back(8'h01);
        exp_q     = expected_frame(8'd8, pl);
        exp_name  = "link";
        exp_valid = 1'b1;
        ready_mode = 1;
        wait_reply(1000);
        report("link", e0);

        if (!aborted) run_query("type", 8'd5, 8'd9, `DAQ_ADC_ID, 8'(`DAQ_BLOCK));
        if (!aborted) run_query("temp", 8'd6, 8'd10, adc_temp, 8'h00);

        ready_mode = 2;
        for (int k = 0; k < 7; k++) begin
            if (!aborted) run_conv(k);
        end
        ready_mode = 1;

        // corrupt checksum is dropped without a reply
        if (!aborted) begin
            e0 = errors;
            f0 = frames_seen;
            send_cmd(8'd7, 8'd6);
            n = 0;
            while (frames_seen == f0 && n < 300) begin
                @(negedge clk);
                n++;
            end
            assert (frames_seen == f0) else begin
                errors++;
                $display("a frame was sent in reply to a command with a bad checksum");
            end
            report("bad_csum", e0);
        end
        if (!aborted) run_query("type_after_error", 8'd5, 8'd9, `DAQ_ADC_ID, 8'(`DAQ_BLOCK));

        $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_ok, tests_run - tests_ok, errors);
        if (errors == 0 && !aborted) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* source/daq_top.sv */
`timescale 1ns/1ps

module daq_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready,
    input  logic [7:0] adc_data,
    input  logic       adc_valid,
    input  logic [7:0] adc_temp
);
    logic               fs_adc_init;
    logic               fd_adc_init;
    logic               fs_adc_type;
    logic               fd_adc_type;
    logic               fs_adc_conf;
    logic               fd_adc_conf;
    logic               fs_adc_conv;
    logic               fd_adc_conv;
    logic               fs_adc_tran;
    logic               fd_adc_tran;
    logic               fs_com_send;
    logic               fd_com_send;
    logic               fd_com_txer;
    logic               fs_com_read;
    logic               fd_com_read;
    daq_pkg::bag_type_t read_btype;
    daq_pkg::bag_type_t send_btype;
    daq_pkg::ram_len_t  ram_dlen;
    daq_pkg::ram_addr_t ram_addr_init;

    // adc_front writes through port a, pkt_tx reads through port b
    wb_if wb_adc ();
    wb_if wb_tx ();

    console u_console (.*);

    adc_front u_adc_front (
        .*,
        .wb (wb_adc)
    );

    ram_wb u_ram_wb (
        .clk (clk),
        .rst (rst),
        .a   (wb_adc),
        .b   (wb_tx)
    );

    pkt_tx u_pkt_tx (
        .*,
        .wb (wb_tx)
    );

    pkt_rx u_pkt_rx (.*);

endmodule

/* source/pkt_rx.sv */
`timescale 1ns/1ps
`include "daq_config.svh"

module pkt_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         rx_data,
    input  logic               rx_valid,
    output logic               fs_com_read,
    input  logic               fd_com_read,
    output daq_pkg::bag_type_t read_btype
);
    typedef enum logic [1:0] {R_SYNC, R_TYPE, R_CSUM, R_HOLD} state_t;

    state_t     state;
    logic [7:0] type_byte;

    assign fs_com_read = (state == R_HOLD);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= R_SYNC;
            type_byte  <= '0;
            read_btype <= daq_pkg::BAG_INIT;
        end else begin
            case (state)
                // anything ahead of a sync byte is dropped
                R_SYNC: if (rx_valid && rx_data == `DAQ_SYNC) state <= R_TYPE;
                R_TYPE: begin
                    if (rx_valid) begin
                        type_byte <= rx_data;
                        state     <= R_CSUM;
                    end
                end
                R_CSUM: begin
                    if (rx_valid) begin
                        // single-byte body, so the checksum equals the type byte
                        if (rx_data == type_byte) read_btype <= daq_pkg::bag_type_t'(type_byte[3:0]);
                        else read_btype <= daq_pkg::BAG_ERROR;
                        state <= R_HOLD;
                    end
                end
                default: if (fd_com_read) state <= R_SYNC;
            endcase
        end
    end

endmodule

/* source/pkt_tx.sv */
`timescale 1ns/1ps
`include "daq_config.svh"

module pkt_tx (
    input  logic               clk,
    input  logic               rst,
    input  logic               fs_com_send,
    input  daq_pkg::bag_type_t send_btype,
    input  daq_pkg::ram_addr_t ram_addr_init,
    input  daq_pkg::ram_len_t  ram_dlen,
    output logic               fd_com_send,
    output logic               fd_com_txer,
    wb_if.master               wb,
    output logic [7:0]         tx_data,
    output logic               tx_valid,
    input  logic               tx_ready
);
    typedef enum logic [3:0] {
        S_IDLE, S_SYNC, S_TYPE, S_LENH, S_LENL, S_FETCH, S_DATA, S_CSUM, S_DONE, S_TXER
    } state_t;

    state_t            state;
    daq_pkg::ram_len_t cnt;
    logic [7:0]        tx_byte;
    logic [7:0]        csum;
    logic [7:0]        stall;
    logic              sending;
    logic              timeout;

    assign sending = (state == S_SYNC) || (state == S_TYPE) || (state == S_LENH) ||
                     (state == S_LENL) || (state == S_DATA) || (state == S_CSUM);
    assign timeout = sending && !tx_ready && (stall == 8'(`DAQ_TX_TIMEOUT - 1));

    assign tx_valid    = sending;
    assign tx_data     = tx_byte;
    assign fd_com_send = (state == S_DONE);
    assign fd_com_txer = (state == S_TXER);

    assign wb.cyc   = (state == S_FETCH);
    assign wb.stb   = (state == S_FETCH);
    assign wb.we    = 1'b0;
    assign wb.adr   = ram_addr_init + cnt;
    assign wb.dat_w = 8'h00;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stall <= '0;
            csum  <= '0;
        end else begin
            stall <= (sending && !tx_ready) ? stall + 8'd1 : 8'd0;
            // checksum covers the type byte through the last data byte
            if (state == S_IDLE) csum <= '0;
            else if (sending && tx_ready && state != S_SYNC && state != S_CSUM) csum <= csum ^ tx_byte;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            cnt     <= '0;
            tx_byte <= '0;
        end else if (timeout) begin
            state <= S_TXER;
        end else begin
            case (state)
                S_IDLE: begin
                    cnt     <= '0;
                    tx_byte <= `DAQ_SYNC;
                    if (fs_com_send) state <= S_SYNC;
                end
                S_SYNC: begin
                    if (tx_ready) begin
                        tx_byte <= {4'h0, send_btype};
                        state   <= S_TYPE;
                    end
                end
                S_TYPE: begin
                    if (tx_ready) begin
                        tx_byte <= {4'h0, ram_dlen[11:8]};
                        state   <= S_LENH;
                    end
                end
                S_LENH: begin
                    if (tx_ready) begin
                        tx_byte <= ram_dlen[7:0];
                        state   <= S_LENL;
                    end
                end
                S_LENL: begin
                    if (tx_ready && ram_dlen == '0) begin
                        tx_byte <= csum ^ tx_byte;
                        state   <= S_CSUM;
                    end else if (tx_ready) begin
                        state <= S_FETCH;
                    end
                end
                // each data byte is read from RAM before it is presented
                S_FETCH: begin
                    if (wb.ack) begin
                        tx_byte <= wb.dat_r;
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (tx_ready) begin
                        cnt <= cnt + 12'd1;
                        if (cnt + 12'd1 == ram_dlen) begin
                            tx_byte <= csum ^ tx_byte;
                            state   <= S_CSUM;
                        end else begin
                            state <= S_FETCH;
                        end
                    end
                end
                S_CSUM: if (tx_ready) state <= S_DONE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* source/console.sv */
`timescale 1ns/1ps
`include "daq_config.svh"

module console (
    input  logic               clk,
    input  logic               rst,
    output logic               fs_adc_init,
    input  logic               fd_adc_init,
    output logic               fs_adc_type,
    input  logic               fd_adc_type,
    output logic               fs_adc_conf,
    input  logic               fd_adc_conf,
    output logic               fs_adc_conv,
    input  logic               fd_adc_conv,
    output logic               fs_adc_tran,
    input  logic               fd_adc_tran,
    output logic               fs_com_send,
    input  logic               fd_com_send,
    input  logic               fd_com_txer,
    input  logic               fs_com_read,
    output logic               fd_com_read,
    input  daq_pkg::bag_type_t read_btype,
    output daq_pkg::bag_type_t send_btype,
    output daq_pkg::ram_len_t  ram_dlen,
    output daq_pkg::ram_addr_t ram_addr_init
);
    typedef enum logic [3:0] {
        MAIN_IDLE, LINK_WORK, LINK_WAIT, LINK_TAKE, LINK_SEND, LINK_DONE,
        MAIN_WAIT, MAIN_TAKE, CMD_IDLE, CMD_WORK, CMD_TAKE, CMD_SEND, CMD_DONE
    } state_t;

    state_t             state;
    state_t             next_state;
    daq_pkg::bag_type_t cmd;
    logic [7:0]         polls;
    logic [2:0]         frame;
    logic               cmd_valid;
    logic               cmd_done;
    logic               is_conv;

    assign is_conv   = (cmd == daq_pkg::BAG_DDIDX);
    assign cmd_valid = (cmd == daq_pkg::BAG_DIDX) || (cmd == daq_pkg::BAG_DPARAM) || is_conv;

    assign fs_adc_init = (state == LINK_WORK);
    assign fs_adc_type = (state == CMD_WORK) && (cmd == daq_pkg::BAG_DIDX);
    assign fs_adc_conf = (state == CMD_WORK) && (cmd == daq_pkg::BAG_DPARAM);
    assign fs_adc_conv = (state == CMD_WORK) && is_conv;
    assign fs_adc_tran = (state == CMD_SEND) && is_conv;
    assign fs_com_send = (state == LINK_SEND) || (state == CMD_SEND);
    // acknowledge the held command, pkt_rx releases it in response
    assign fd_com_read = (state == CMD_IDLE);

    always_comb begin
        case (cmd)
            daq_pkg::BAG_DIDX:   cmd_done = fd_adc_type;
            daq_pkg::BAG_DPARAM: cmd_done = fd_adc_conf;
            daq_pkg::BAG_DDIDX:  cmd_done = fd_adc_conv;
            default:             cmd_done = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            MAIN_IDLE: next_state = LINK_WORK;
            LINK_WORK: if (fd_adc_init) next_state = LINK_WAIT;
            LINK_WAIT: if (polls >= 8'(`DAQ_LINK_POLLS - 1)) next_state = LINK_TAKE;
            LINK_TAKE: next_state = LINK_SEND;
            LINK_SEND: begin
                if (fd_com_send) next_state = LINK_DONE;
                else if (fd_com_txer) next_state = LINK_WAIT;
            end
            LINK_DONE: next_state = MAIN_WAIT;
            MAIN_WAIT: if (fs_com_read) next_state = MAIN_TAKE;
            MAIN_TAKE: next_state = CMD_IDLE;
            // error frames and unknown types are dropped here
            CMD_IDLE: if (!fs_com_read) next_state = cmd_valid ? CMD_WORK : MAIN_WAIT;
            CMD_WORK: if (cmd_done) next_state = CMD_TAKE;
            CMD_TAKE: next_state = CMD_SEND;
            CMD_SEND: begin
                // a stalled host forces a fresh link announcement
                if (fd_com_txer) next_state = LINK_WAIT;
                else if (fd_com_send && (!is_conv || fd_adc_tran)) next_state = CMD_DONE;
            end
            CMD_DONE: next_state = MAIN_WAIT;
            default: next_state = MAIN_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MAIN_IDLE;
            cmd   <= daq_pkg::BAG_INIT;
            polls <= '0;
            frame <= '0;
        end else begin
            state <= next_state;
            polls <= (state == LINK_WAIT) ? polls + 8'd1 : 8'd0;
            if (state == MAIN_TAKE) cmd <= read_btype;
            // data buffer ring, kept in step with the adc_front write ring
            if (state == CMD_TAKE && is_conv) frame <= (frame == 3'(`DAQ_FRAMES - 1)) ? 3'd0 : frame + 3'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            send_btype    <= daq_pkg::BAG_INIT;
            ram_addr_init <= `DAQ_ADDR_INIT;
            ram_dlen      <= '0;
        end else if (state == LINK_TAKE) begin
            send_btype    <= daq_pkg::BAG_DLINK;
            ram_addr_init <= `DAQ_ADDR_LINK;
            ram_dlen      <= 12'd2;
        end else if (state == CMD_TAKE) begin
            case (cmd)
                daq_pkg::BAG_DIDX: begin
                    send_btype    <= daq_pkg::BAG_DTYPE;
                    ram_addr_init <= `DAQ_ADDR_TYPE;
                end
                daq_pkg::BAG_DPARAM: begin
                    send_btype    <= daq_pkg::BAG_DTEMP;
                    ram_addr_init <= `DAQ_ADDR_TEMP;
                end
                default: begin
                    send_btype    <= frame[0] ? daq_pkg::BAG_DATA1 : daq_pkg::BAG_DATA0;
                    ram_addr_init <= `DAQ_ADDR_DATA0 + frame * `DAQ_FRAME_STRIDE;
                end
            endcase
            ram_dlen <= is_conv ? 12'(2 + `DAQ_BLOCK) : 12'd2;
        end else if (state == MAIN_WAIT) begin
            send_btype    <= daq_pkg::BAG_INIT;
            ram_addr_init <= `DAQ_ADDR_INIT;
            ram_dlen      <= '0;
        end
    end

endmodule

/* source/adc_front.sv */
`timescale 1ns/1ps
`include "daq_config.svh"

module adc_front (
    input  logic       clk,
    input  logic       rst,
    input  logic       fs_adc_init,
    output logic       fd_adc_init,
    input  logic       fs_adc_type,
    output logic       fd_adc_type,
    input  logic       fs_adc_conf,
    output logic       fd_adc_conf,
    input  logic       fs_adc_conv,
    output logic       fd_adc_conv,
    input  logic       fs_adc_tran,
    output logic       fd_adc_tran,
    input  logic [7:0] adc_data,
    input  logic       adc_valid,
    input  logic [7:0] adc_temp,
    wb_if.master       wb
);
    typedef enum logic [1:0] {OP_INIT, OP_TYPE, OP_CONF, OP_CONV} op_t;
    typedef enum logic [1:0] {ST_IDLE, ST_WR, ST_SAMP, ST_DONE} state_t;

    state_t             state;
    op_t                op;
    daq_pkg::ram_addr_t base;
    daq_pkg::ram_len_t  idx;
    daq_pkg::ram_len_t  last;
    logic [2:0]         wr_frame;
    logic [7:0]         sample;
    logic [7:0]         word;

    // index of the final word, two header words plus the block for a conversion
    assign last = (op == OP_CONV) ? 12'(`DAQ_BLOCK + 1) : 12'd1;

    always_comb begin
        word = sample;
        if (idx == 12'd0) begin
            case (op)
                OP_INIT: word = `DAQ_LINK_WORD;
                OP_TYPE: word = `DAQ_ADC_ID;
                OP_CONF: word = adc_temp;
                default: word = {5'd0, wr_frame};
            endcase
        end else if (idx == 12'd1) begin
            case (op)
                OP_INIT: word = 8'h01;
                OP_CONF: word = 8'h00;
                default: word = 8'(`DAQ_BLOCK);
            endcase
        end
    end

    assign wb.cyc   = (state == ST_WR);
    assign wb.stb   = (state == ST_WR);
    assign wb.we    = (state == ST_WR);
    assign wb.adr   = base + idx;
    assign wb.dat_w = word;

    assign fd_adc_init = (state == ST_DONE) && (op == OP_INIT);
    assign fd_adc_type = (state == ST_DONE) && (op == OP_TYPE);
    assign fd_adc_conf = (state == ST_DONE) && (op == OP_CONF);
    assign fd_adc_conv = (state == ST_DONE) && (op == OP_CONV);
    assign fd_adc_tran = !((state == ST_WR || state == ST_SAMP) && op == OP_CONV);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            op       <= OP_INIT;
            base     <= '0;
            idx      <= '0;
            wr_frame <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    idx   <= '0;
                    state <= ST_WR;
                    if (fs_adc_init) begin
                        op   <= OP_INIT;
                        base <= `DAQ_ADDR_LINK;
                    end else if (fs_adc_type) begin
                        op   <= OP_TYPE;
                        base <= `DAQ_ADDR_TYPE;
                    end else if (fs_adc_conf) begin
                        op   <= OP_CONF;
                        base <= `DAQ_ADDR_TEMP;
                    end else if (fs_adc_conv && !fs_adc_tran) begin
                        op   <= OP_CONV;
                        base <= `DAQ_ADDR_DATA0 + wr_frame * `DAQ_FRAME_STRIDE;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_WR: begin
                    if (wb.ack) begin
                        idx <= idx + 12'd1;
                        if (idx == last) state <= ST_DONE;
                        else if (op == OP_CONV && idx != 12'd0) state <= ST_SAMP;
                    end
                end
                // one sample accepted per write, adc_valid is ignored mid-write
                ST_SAMP: if (adc_valid) state <= ST_WR;
                default: begin
                    if (op == OP_CONV) wr_frame <= (wr_frame == 3'(`DAQ_FRAMES - 1)) ? 3'd0 : wr_frame + 3'd1;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_SAMP && adc_valid) sample <= adc_data;
    end

endmodule

/* source/ram_wb.sv */
`timescale 1ns/1ps

module ram_wb (
    input  logic clk,
    input  logic rst,
    wb_if.slave  a,
    wb_if.slave  b
);
    logic [7:0] mem [0:4095];
    logic       a_ack;
    logic       b_ack;
    logic [7:0] b_dat;

    // port a only writes, its read data is tied off
    assign a.ack   = a_ack;
    assign a.dat_r = 8'h00;
    assign b.ack   = b_ack;
    assign b.dat_r = b_dat;

    // ack one cycle after stb, then low for a cycle before the next word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_ack <= 1'b0;
            b_ack <= 1'b0;
        end else begin
            a_ack <= a.cyc && a.stb && !a_ack;
            b_ack <= b.cyc && b.stb && !b_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (a.cyc && a.stb && a.we && !a_ack) mem[a.adr] <= a.dat_w;
        if (b.cyc && b.stb && !b.we && !b_ack) b_dat <= mem[b.adr];
    end

endmodule

/* source/wb_if.sv */
`timescale 1ns/1ps

interface wb_if;
    logic               cyc;
    logic               stb;
    logic               we;
    daq_pkg::ram_addr_t adr;
    logic [7:0]         dat_w;
    logic [7:0]         dat_r;
    logic               ack;

    // classic cycle, master holds cyc and stb until a one-cycle ack
    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );
endinterface

/* source/daq_pkg.sv */
package daq_pkg;

    // packet types carried in the type byte of every frame
    typedef enum logic [3:0] {
        BAG_INIT   = 4'd0,
        // host commands
        BAG_DIDX   = 4'd5,
        BAG_DPARAM = 4'd6,
        BAG_DDIDX  = 4'd7,
        // console replies
        BAG_DLINK  = 4'd8,
        BAG_DTYPE  = 4'd9,
        BAG_DTEMP  = 4'd10,
        BAG_DATA0  = 4'd13,
        BAG_DATA1  = 4'd14,
        BAG_ERROR  = 4'd15
    } bag_type_t;

    // byte address and byte length into the shared RAM
    typedef logic [11:0] ram_addr_t;
    typedef logic [11:0] ram_len_t;

endpackage

/* include/daq_config.svh */
`ifndef DAQ_CONFIG_SVH
`define DAQ_CONFIG_SVH

`define DAQ_SYNC          8'hA5

// RAM regions
`define DAQ_ADDR_INIT     12'hFE0
`define DAQ_ADDR_LINK     12'hFCC
`define DAQ_ADDR_TYPE     12'hFC0
`define DAQ_ADDR_TEMP     12'hFC4
`define DAQ_ADDR_DATA0    12'h000
`define DAQ_FRAME_STRIDE  12'h240
`define DAQ_FRAMES        6

// samples per conversion block
`define DAQ_BLOCK         16
`define DAQ_LINK_POLLS    12
`define DAQ_TX_TIMEOUT    64
`define DAQ_ADC_ID        8'h3C
`define DAQ_LINK_WORD     8'h5A

`endif
